/* inverse_cdf.f */
source/fixed_point_pkg.sv
source/inverse_cdf_pkg.sv
source/cdf_fold.sv
source/ln_lut.sv
source/fixed_mul.sv
source/fixed_sqrt.sv
source/fixed_div.sv
source/zs_rational.sv
source/inverse_cdf.sv
sim/inverse_cdf_tb.sv

/* Bender.yml */
package:
  name: inverse_cdf

sources:
  - files:
      - source/fixed_point_pkg.sv
      - source/inverse_cdf_pkg.sv
      - source/cdf_fold.sv
      - source/ln_lut.sv
      - source/fixed_mul.sv
      - source/fixed_sqrt.sv
      - source/fixed_div.sv
      - source/zs_rational.sv
      - source/inverse_cdf.sv
  - target: test
    files:
      - sim/inverse_cdf_tb.sv

/* sim/inverse_cdf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module inverse_cdf_tb;
    import fixed_point_pkg::*;

    localparam int  CLK_PERIOD   = 10;
    localparam int  RESET_CYCLES = 16;
    localparam int  IDLE_CYCLES  = 20;
    localparam int  LATENCY      = 33;   // valid_in to valid_out
    localparam int  N_KNOWN      = 3;
    localparam int  N_BURST      = 64;
    localparam int  N_RANDOM     = 400;
    localparam int  N_PAIRS      = 32;
    localparam int  MAX_GAP      = 3;
    localparam int  N_SAMPLES    = N_KNOWN + N_BURST + N_RANDOM + 2 * N_PAIRS;
    localparam int  WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + N_SAMPLES * (MAX_GAP + 1)
                                      + 2 * LATENCY + 100;
    localparam real TOL          = 0.004;
    localparam real SCALE        = 2097152.0;   // Weight of 1.0 in Q11.21
    localparam int  U_LO         = 2048;        // 2^-10 in LSBs
    localparam int  U_SPAN       = 2 ** 21 - 2 * U_LO + 1;

    localparam fx_t ONE  = fx_t'(1) <<< FP_QFRAC;
    localparam fx_t HALF = fx_t'(1) <<< (FP_QFRAC - 1);

    localparam logic [1:0] ROLE_PLAIN  = 2'd0;
    localparam logic [1:0] ROLE_KNOWN  = 2'd1;   // Also checked against an ideal z
    localparam logic [1:0] ROLE_PAIR_A = 2'd2;
    localparam logic [1:0] ROLE_PAIR_B = 2'd3;   // Must be the exact negation of the A output

    typedef struct packed {
        fx_t         u;
        logic [31:0] in_cycle;
        logic [1:0]  role;
        fx_t         target;
    } sample_t;

    logic    clk;
    logic    rst_n;
    logic    valid_in;
    fx_t     u_in;
    logic    valid_out;
    fx_t     z_out;

    sample_t pending [$];
    integer  seed = 32'hea7d7b85;
    int      cycle = 0;
    int      in_count = 0;
    int      out_count = 0;
    int      value_errors = 0;
    int      protocol_errors = 0;
    fx_t     pair_z;

    inverse_cdf inverse_cdf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .u_in      (u_in),
        .valid_out (valid_out),
        .z_out     (z_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic fx_t to_fx(input real r);
        fx_t v;
        if (r >= 0.0)
            v = fx_t'($rtoi(r * SCALE + 0.5));
        else
            v = -fx_t'($rtoi(-r * SCALE + 0.5));
        return v;
    endfunction

    // Ideal Zelen-Severo on the folded x, no rounding
    function automatic real ref_z(input fx_t u);
        real ur, x, t, num, den, r;
        ur = $itor(u) / SCALE;
        x  = (ur >= 0.5) ? 1.0 - ur : ur;
        if (x <= 0.0)
            x = 1.0 / SCALE;
        t   = $sqrt(-2.0 * $ln(x));
        num = 2.515517 + 0.802853 * t + 0.010328 * t * t;
        den = 1.0 + 1.432788 * t + 0.189269 * t * t + 0.001308 * t * t * t;
        r   = t - num / den;
        return (ur < 0.5) ? -r : r;
    endfunction

    task automatic send_sample(input fx_t u, input logic [1:0] role, input fx_t target);
        sample_t s;
        s.u        = u;
        s.in_cycle = cycle;
        s.role     = role;
        s.target   = target;
        valid_in   = 1'b1;
        u_in       = u;
        pending.push_back(s);
        in_count++;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic random_u(output fx_t u);
        u = fx_t'(U_LO + ($unsigned($random(seed)) % U_SPAN));   // [2^-10, 1-2^-10]
    endtask

    task automatic check_output;
        sample_t s;
        real     expect_z;
        real     got_z;
        real     err;
        int      latency;
        out_count++;   // Every strobe counts, stray ones too
        assert (pending.size() != 0) else begin
            protocol_errors++;
            $display("valid_out went high at cycle %0d with no sample pending", cycle);
        end
        if (pending.size() != 0) begin
            s = pending.pop_front();
            latency = cycle - int'(s.in_cycle);
            assert (latency == LATENCY) else begin
                protocol_errors++;
                $display("Output for u_in 0x%08h came %0d cycles after its strobe, not %0d",
                         s.u, latency, LATENCY);
            end
            expect_z = ref_z(s.u);
            got_z    = $itor(z_out) / SCALE;
            err      = (got_z > expect_z) ? got_z - expect_z : expect_z - got_z;
            assert (err <= TOL) else begin
                value_errors++;
                $display("FAILED z_out: got 0x%08h expected 0x%08h (u_in 0x%08h)",
                         z_out, to_fx(expect_z), s.u);
            end
            if (s.role == ROLE_KNOWN) begin
                expect_z = $itor(s.target) / SCALE;
                err      = (got_z > expect_z) ? got_z - expect_z : expect_z - got_z;
                assert (err <= TOL) else begin
                    value_errors++;
                    $display("FAILED z_out: got 0x%08h expected 0x%08h (known point u_in 0x%08h)",
                             z_out, s.target, s.u);
                end
            end
            if (s.role == ROLE_PAIR_A)
                pair_z = z_out;
            if (s.role == ROLE_PAIR_B) begin
                assert (z_out == -pair_z) else begin
                    value_errors++;
                    $display("FAILED z_out: got 0x%08h expected 0x%08h (mirror of u_in 0x%08h)",
                             z_out, fx_t'(-pair_z), s.u);
                end
            end
        end
    endtask

    // Outputs are sampled mid-cycle, away from the active edge
    always @(negedge clk) begin
        if (cycle > 0) begin   // Nothing is driven before the first rising edge
            if (!rst_n) begin
                assert (valid_out === 1'b0) else begin
                    protocol_errors++;
                    $display("valid_out was not low during reset at cycle %0d", cycle);
                end
            end else begin
                assert (valid_out === 1'b0 || valid_out === 1'b1) else begin
                    protocol_errors++;
                    $display("valid_out is unknown at cycle %0d", cycle);
                end
                if (valid_out === 1'b1)
                    check_output();
            end
        end
    end

    initial begin
        fx_t u;
        int  gap;
        rst_n    = 1'b0;
        valid_in = 1'b0;
        u_in     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_cycles(IDLE_CYCLES);

        send_sample(to_fx(0.5), ROLE_KNOWN, to_fx(0.0));
        send_sample(to_fx(0.841345), ROLE_KNOWN, to_fx(1.0));
        send_sample(to_fx(0.158655), ROLE_KNOWN, to_fx(-1.0));
        idle_cycles(5);

        repeat (N_BURST) begin   // One strobe every cycle
            random_u(u);
            send_sample(u, ROLE_PLAIN, '0);
        end

        repeat (N_RANDOM) begin
            random_u(u);
            send_sample(u, ROLE_PLAIN, '0);
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            idle_cycles(gap);
        end

        // Mirror pairs u and 1-u
        repeat (N_PAIRS) begin
            random_u(u);
            if (u >= HALF)
                u = ONE - u;
            if (u == HALF)
                u = HALF - 1;
            send_sample(u, ROLE_PAIR_A, '0);
            send_sample(ONE - u, ROLE_PAIR_B, '0);
        end

        wait (out_count >= in_count);
        idle_cycles(LATENCY + 5);   // Stray strobes would land here
        assert (out_count == in_count && pending.size() == 0) else begin
            protocol_errors++;
            $display("Output count %0d does not match input count %0d", out_count, in_count);
        end

        $display("Errors: value %0d, protocol %0d, samples in %0d, samples out %0d",
                 value_errors, protocol_errors, in_count, out_count);
        if (value_errors + protocol_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with %0d of %0d outputs seen",
                 WATCHDOG_CYCLES, out_count, in_count);
        $display("Errors: value %0d, protocol %0d, samples in %0d, samples out %0d",
                 value_errors, protocol_errors, in_count, out_count);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* source/inverse_cdf.sv */
`timescale 1ns/1ps
`default_nettype none

module inverse_cdf (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  fixed_point_pkg::fx_t u_in,    // Uniform sample in [0,1)
    output logic                 valid_out,
    output fixed_point_pkg::fx_t z_out    // Standard-normal z-score
);
    import fixed_point_pkg::*;
    import inverse_cdf_pkg::*;

    localparam fx_t MINUS_TWO = -(fx_t'(2) <<< FP_QFRAC);

    logic                    fold_valid;
    fold_t                   fold;
    logic                    ln_valid;
    fx_t                     ln_x;
    fx_t                     neg2_ln_x;
    logic [MUL_LATENCY-1:0]  mul_valid;
    logic                    t_valid;
    fx_t                     t;
    logic [NEGATE_DELAY-1:0] negate_pipe;

    cdf_fold u_fold (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .u(u_in),
        .valid_out(fold_valid), .fold(fold)
    );

    ln_lut u_ln (
        .clk(clk), .rst_n(rst_n), .valid_in(fold_valid), .x(fold.x),
        .valid_out(ln_valid), .ln_out(ln_x)
    );

    fixed_mul u_mul_neg2 (.clk(clk), .rst_n(rst_n), .a(ln_x), .b(MINUS_TWO), .result(neg2_ln_x));

    // Valid follows the multiplier, which carries none of its own
    always_ff @(posedge clk) begin
        if (!rst_n)
            mul_valid <= '0;
        else
            mul_valid <= {mul_valid[MUL_LATENCY-2:0], ln_valid};
    end

    fixed_sqrt u_sqrt (
        .clk(clk), .rst_n(rst_n), .valid_in(mul_valid[MUL_LATENCY-1]), .a(neg2_ln_x),
        .valid_out(t_valid), .sqrt_out(t)
    );

    always_ff @(posedge clk) begin
        negate_pipe <= {negate_pipe[NEGATE_DELAY-2:0], fold.negate};  // Lines up with t
    end

    zs_rational u_zs (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (t_valid),
        .t         (t),
        .negate    (negate_pipe[NEGATE_DELAY-1]),
        .valid_out (valid_out),
        .z         (z_out)
    );

endmodule

`default_nettype wire

/* source/zs_rational.sv */
`timescale 1ns/1ps
`default_nettype none

module zs_rational (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  fixed_point_pkg::fx_t t,
    input  logic                 negate,
    output logic                 valid_out,
    output fixed_point_pkg::fx_t z
);
    import fixed_point_pkg::*;
    import inverse_cdf_pkg::*;

    localparam int POLY_CYCLES = ZS_LATENCY - DIV_LATENCY - 1;
    localparam int T_DELAY     = ZS_LATENCY - 1;
    localparam fx_t ONE        = fx_t'(1) <<< FP_QFRAC;

    // Small constant times t, coefficients are far below one
    function automatic fx_t scale(input fx_t coef, input fx_t v);
        fx_wide_t p;
        p = fx_wide_t'(coef) * fx_wide_t'(v);
        return fx_t'(p >>> FP_QFRAC);
    endfunction

    fx_t                     t_pipe [T_DELAY];   // t_pipe[k] is t delayed k+1 cycles
    logic [T_DELAY-1:0]      neg_pipe;
    logic [POLY_CYCLES-1:0]  valid_pipe;
    fx_t                     num_head;
    fx_t                     den_head;
    fx_t                     num_prod;
    fx_t                     den_prod1;
    fx_t                     den_mid;
    fx_t                     den_prod2;
    fx_t                     num_pipe [2];
    fx_t                     num_div;
    fx_t                     den_div;
    logic                    div_valid;
    fx_t                     quot;
    fx_t                     diff;

    always_ff @(posedge clk) begin
        t_pipe[0] <= t;
        for (int k = 1; k < T_DELAY; k++)
            t_pipe[k] <= t_pipe[k-1];
        neg_pipe <= {neg_pipe[T_DELAY-2:0], negate};
    end

    // Horner heads, c1 + c2*t and d2 + d3*t
    always_ff @(posedge clk) begin
        num_head <= ZS_C1 + scale(ZS_C2, t);
        den_head <= ZS_D2 + scale(ZS_D3, t);
    end

    fixed_mul u_mul_num  (.clk(clk), .rst_n(rst_n), .a(t_pipe[0]), .b(num_head), .result(num_prod));
    fixed_mul u_mul_den1 (.clk(clk), .rst_n(rst_n), .a(t_pipe[0]), .b(den_head), .result(den_prod1));

    assign den_mid = ZS_D1 + den_prod1;

    fixed_mul u_mul_den2 (.clk(clk), .rst_n(rst_n), .a(t_pipe[2]), .b(den_mid), .result(den_prod2));

    // Numerator is ready two cycles early and waits for the denominator
    always_ff @(posedge clk) begin
        num_pipe[0] <= ZS_C0 + num_prod;
        num_pipe[1] <= num_pipe[0];
        num_div     <= num_pipe[1];
        den_div     <= ONE + den_prod2;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[POLY_CYCLES-2:0], valid_in};
    end

    fixed_div u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_pipe[POLY_CYCLES-1]),
        .num       (num_div),
        .den       (den_div),
        .valid_out (div_valid),
        .quot      (quot)
    );

    assign diff = t_pipe[T_DELAY-1] - quot;

    always_ff @(posedge clk) begin
        z <= neg_pipe[T_DELAY-1] ? -diff : diff;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_out <= 1'b0;
        else
            valid_out <= div_valid;
    end

endmodule

`default_nettype wire

/* source/fixed_div.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_div (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  fixed_point_pkg::fx_t num,
    input  fixed_point_pkg::fx_t den,
    output logic                 valid_out,
    output fixed_point_pkg::fx_t quot
);
    import fixed_point_pkg::*;
    import inverse_cdf_pkg::*;

    localparam int QUOT_W = 2 * DIV_LATENCY;   // 3 integer bits, 21 fraction bits
    localparam int REM_W  = FP_WIDTH + 1;

    typedef struct packed {
        fx_wide_t             dvd;   // Remaining dividend bits, next one at QUOT_W-1
        logic [REM_W-1:0]     rem;
        logic [FP_WIDTH-1:0]  den;
        logic [QUOT_W-1:0]    quot;
    } div_state_t;

    // Two restoring steps per stage
    function automatic div_state_t div_step(input div_state_t s);
        div_state_t       n;
        logic [REM_W-1:0] shifted;
        n = s;
        for (int k = 0; k < 2; k++) begin
            shifted = {n.rem[REM_W-2:0], n.dvd[QUOT_W-1]};
            n.dvd   = n.dvd << 1;
            if (shifted >= {1'b0, n.den}) begin
                n.rem  = shifted - {1'b0, n.den};
                n.quot = {n.quot[QUOT_W-2:0], 1'b1};
            end else begin
                n.rem  = shifted;
                n.quot = {n.quot[QUOT_W-2:0], 1'b0};
            end
        end
        return n;
    endfunction

    fx_wide_t               dvd_full;
    div_state_t             first;
    div_state_t             stage_q [DIV_LATENCY];
    logic [DIV_LATENCY-1:0] valid_q;

    assign dvd_full = fx_wide_t'(num) <<< FP_QFRAC;

    always_comb begin
        first      = '0;
        first.dvd  = dvd_full;
        first.rem  = dvd_full[QUOT_W +: REM_W];   // Bits above the quotient range
        first.den  = den;
    end

    for (genvar s = 0; s < DIV_LATENCY; s++) begin : g_stage
        if (s == 0) begin : g_first
            always_ff @(posedge clk) stage_q[0] <= div_step(first);
        end else begin : g_next
            always_ff @(posedge clk) stage_q[s] <= div_step(stage_q[s-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= '0;
        else
            valid_q <= {valid_q[DIV_LATENCY-2:0], valid_in};
    end

    assign valid_out = valid_q[DIV_LATENCY-1];
    assign quot      = fx_t'(stage_q[DIV_LATENCY-1].quot);

endmodule

`default_nettype wire

/* source/fixed_sqrt.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_sqrt (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  fixed_point_pkg::fx_t a,
    output logic                 valid_out,
    output fixed_point_pkg::fx_t sqrt_out
);
    import fixed_point_pkg::*;
    import inverse_cdf_pkg::*;

    localparam int ROOT_W = 24;
    localparam int REM_W  = 30;
    localparam int STEP_BITS = ROOT_W / SQRT_LATENCY;   // 3 root bits per stage
    localparam fx_wide_t RAD_MAX = (fx_wide_t'(1) <<< (2 * ROOT_W)) - 1;

    typedef struct packed {
        fx_wide_t                 rad;    // Unconsumed radicand bits, MSB pair at 47:46
        logic signed [REM_W-1:0]  rem;
        logic [ROOT_W-1:0]        root;
    } sqrt_state_t;

    // Non-restoring iteration, remainder sign picks add or subtract
    function automatic sqrt_state_t sqrt_step(input sqrt_state_t s);
        sqrt_state_t n;
        n = s;
        for (int k = 0; k < STEP_BITS; k++) begin
            if (n.rem >= 0)
                n.rem = {n.rem[REM_W-3:0], n.rad[2*ROOT_W-1 -: 2]} - {n.root, 2'b01};
            else
                n.rem = {n.rem[REM_W-3:0], n.rad[2*ROOT_W-1 -: 2]} + {n.root, 2'b11};
            n.root = {n.root[ROOT_W-2:0], ~n.rem[REM_W-1]};
            n.rad  = n.rad << 2;
        end
        return n;
    endfunction

    fx_wide_t            rad_full;
    sqrt_state_t         first;
    sqrt_state_t         stage_q [SQRT_LATENCY];
    logic [SQRT_LATENCY-1:0] valid_q;

    assign rad_full = fx_wide_t'(a) <<< FP_QFRAC;

    always_comb begin
        first = '0;
        if (a < 0)
            first.rad = '0;                // Negative input gives zero
        else if (rad_full > RAD_MAX)
            first.rad = RAD_MAX;           // Clamp to the widest root
        else
            first.rad = rad_full;
    end

    for (genvar s = 0; s < SQRT_LATENCY; s++) begin : g_stage
        if (s == 0) begin : g_first
            always_ff @(posedge clk) stage_q[0] <= sqrt_step(first);
        end else begin : g_next
            always_ff @(posedge clk) stage_q[s] <= sqrt_step(stage_q[s-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= '0;
        else
            valid_q <= {valid_q[SQRT_LATENCY-2:0], valid_in};
    end

    assign valid_out = valid_q[SQRT_LATENCY-1];
    assign sqrt_out  = fx_t'(stage_q[SQRT_LATENCY-1].root);

endmodule

`default_nettype wire

/* source/fixed_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_mul (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fixed_point_pkg::fx_t a,
    input  fixed_point_pkg::fx_t b,
    output fixed_point_pkg::fx_t result
);
    import fixed_point_pkg::*;

    localparam fx_wide_t FX_MAX = fx_wide_t'({1'b0, {(FP_WIDTH-1){1'b1}}});
    localparam fx_wide_t FX_MIN = -FX_MAX - 1;
    localparam fx_wide_t HALF_LSB = fx_wide_t'(1) <<< (FP_QFRAC - 1);

    fx_wide_t prod_q;
    fx_wide_t scaled;

    assign scaled = (prod_q + HALF_LSB) >>> FP_QFRAC;  // Round half up

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_q <= '0;
            result <= '0;
        end else begin
            prod_q <= fx_wide_t'(a) * fx_wide_t'(b);
            if (scaled > FX_MAX)
                result <= fx_t'(FX_MAX);
            else if (scaled < FX_MIN)
                result <= fx_t'(FX_MIN);
            else
                result <= fx_t'(scaled);
        end
    end

endmodule

`default_nettype wire

/* source/ln_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module ln_lut (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  fixed_point_pkg::fx_t x,
    output logic                 valid_out,
    output fixed_point_pkg::fx_t ln_out
);
    import fixed_point_pkg::*;
    import inverse_cdf_pkg::*;

    localparam int TABLE_SIZE = 2 ** LUT_BITS;

    typedef logic signed [5:0]            exp_t;   // Binary exponent of x
    typedef logic [LUT_BITS-1:0]          mant_t;
    typedef logic [$clog2(FP_WIDTH)-1:0]  pos_t;

    // Each entry sits in the middle of its mantissa bin to halve the error
    function automatic fx_t ln_entry(input int m);
        real r;
        r = $ln(1.0 + (real'(m) + 0.5) / real'(TABLE_SIZE));
        return fx_t'($rtoi(r * real'(2 ** FP_QFRAC) + 0.5));
    endfunction

    fx_t                   ln_table [TABLE_SIZE];
    pos_t                  lead;
    logic [FP_WIDTH-1:0]   norm;
    mant_t                 mant_q;
    exp_t                  exp_q1;
    exp_t                  exp_q2;
    fx_t                   tab_q;
    logic [LN_LATENCY-1:0] valid_q;

    for (genvar i = 0; i < TABLE_SIZE; i++) begin : g_table
        assign ln_table[i] = ln_entry(i);
    end

    // Leading one of the magnitude bits
    always_comb begin
        lead = '0;
        for (int i = 0; i < FP_WIDTH - 1; i++) begin
            if (x[i])
                lead = pos_t'(i);
        end
    end

    assign norm = x << (FP_WIDTH - 2 - int'(lead));  // Leading one moved to bit 30

    always_ff @(posedge clk) begin
        mant_q <= norm[FP_WIDTH-3 -: LUT_BITS];
        exp_q1 <= exp_t'(int'(lead) - FP_QFRAC);
        tab_q  <= ln_table[mant_q];
        exp_q2 <= exp_q1;
        ln_out <= tab_q + fx_t'(exp_q2) * LN2_FX;   // ln(x) = ln(1+m) + e*ln2
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= '0;
        else
            valid_q <= {valid_q[LN_LATENCY-2:0], valid_in};
    end

    assign valid_out = valid_q[LN_LATENCY-1];

endmodule

`default_nettype wire

/* source/cdf_fold.sv */
`timescale 1ns/1ps
`default_nettype none

module cdf_fold (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_in,
    input  fixed_point_pkg::fx_t   u,
    output logic                   valid_out,
    output inverse_cdf_pkg::fold_t fold
);
    import fixed_point_pkg::*;

    localparam fx_t ONE  = fx_t'(1) <<< FP_QFRAC;
    localparam fx_t HALF = fx_t'(1) <<< (FP_QFRAC - 1);

    fx_t  x_next;
    logic negate_next;

    // Upper half mirrors onto the lower half, lower half is the negative tail
    always_comb begin
        if (u >= HALF) begin
            x_next      = ONE - u;
            negate_next = 1'b0;
        end else begin
            x_next      = u;
            negate_next = 1'b1;
        end
        if (x_next == '0)
            x_next = fx_t'(1);  // u = 0 lands on the smallest x
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk) begin
        fold.x      <= x_next;
        fold.negate <= negate_next;
    end

endmodule

`default_nettype wire

/* source/inverse_cdf_pkg.sv */
`default_nettype none

package inverse_cdf_pkg;

    // Mantissa bits that index the ln table
    localparam int LUT_BITS = 8;

    // Stage latencies in clock cycles
    localparam int FOLD_LATENCY = 1;
    localparam int LN_LATENCY   = 3;   // Normalize, table read, exponent add
    localparam int MUL_LATENCY  = 2;
    localparam int SQRT_LATENCY = 8;
    localparam int DIV_LATENCY  = 12;
    localparam int ZS_LATENCY   = 6 + DIV_LATENCY + 1;

    // Negate flag travels from the fold output to the rational stage input
    localparam int NEGATE_DELAY = LN_LATENCY + MUL_LATENCY + SQRT_LATENCY;

    localparam int TOTAL_LATENCY = FOLD_LATENCY + NEGATE_DELAY + ZS_LATENCY;

    // Zelen-Severo coefficients in Q11.21
    localparam fixed_point_pkg::fx_t ZS_C0 = 5275422;   // 2.515517
    localparam fixed_point_pkg::fx_t ZS_C1 = 1683705;   // 0.802853
    localparam fixed_point_pkg::fx_t ZS_C2 = 21659;     // 0.010328
    localparam fixed_point_pkg::fx_t ZS_D1 = 3004774;   // 1.432788
    localparam fixed_point_pkg::fx_t ZS_D2 = 396926;    // 0.189269
    localparam fixed_point_pkg::fx_t ZS_D3 = 2743;      // 0.001308

    localparam fixed_point_pkg::fx_t LN2_FX = 1453635;  // ln 2

    // Folded sample, x in (0,0.5] plus the sign to restore at the end
    typedef struct packed {
        fixed_point_pkg::fx_t x;
        logic                 negate;
    } fold_t;

endpackage

`default_nettype wire

/* source/fixed_point_pkg.sv */
`default_nettype none

package fixed_point_pkg;

    // Q11.21 signed fixed point
    localparam int FP_WIDTH = 32;
    localparam int FP_QINT  = 11;   // Integer bits, sign included
    localparam int FP_QFRAC = 21;

    // One arithmetic value
    typedef logic signed [FP_WIDTH-1:0] fx_t;

    // Full products and pre-shifted dividends or radicands
    typedef logic signed [2*FP_WIDTH-1:0] fx_wide_t;

endpackage

`default_nettype wire
